// ==== compile.f ====
logic/ddc_pkg.sv
logic/ddc_nco_x2.sv
logic/ddc_mixer.sv
logic/ddc_halfband.sv
logic/ddc_top.sv
verif/ddc_tb.sv

// ==== Makefile ====
# Verilator build and run for the down-converter testbench.

VERILATOR ?= verilator
TOP       ?= ddc_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(BUILD_DIR)

// ==== verif/ddc_tb.sv ====
`timescale 1ns/1ps

`default_nettype none

module ddc_tb;

localparam integer WIDTH = 16;
localparam integer LATENCY = 6; // the oscillator lookup overlaps mixer stage 0.
localparam integer MAX_VAL = 2 ** (WIDTH - 1) - 1;
localparam integer MIN_VAL = -(2 ** (WIDTH - 1));
localparam integer DRAIN_TIMEOUT = 40;
localparam integer NUM_ROWS = 6;
localparam real PI = 3.14159265358979323846;

typedef logic signed [WIDTH-1:0] sample_t;
typedef enum logic [1:0] {PAT_CONST, PAT_RAMP, PAT_RANDOM, PAT_STEPS} pattern_t;

typedef struct packed {
    ddc_pkg::phase_t phase_inc;
    logic            retune;
    ddc_pkg::phase_t retune_inc;
    pattern_t        pattern;
    logic [7:0]      pairs;
    logic            gaps;
    logic            expect_sat;
} row_t;

typedef struct packed {
    sample_t inph;
    sample_t quad;
    logic    check;
    int      cycle;
} expect_t;

string row_names [NUM_ROWS] = '{"dc_zero_inc", "tone_fs16", "retune", "random_gaps",
                                "full_scale_ramp", "full_scale_steps"};
row_t rows [NUM_ROWS] = '{
    '{32'h0000_0000, 1'b0, 32'h0000_0000, PAT_CONST,  8'd24, 1'b0, 1'b0},
    '{32'h1000_0000, 1'b0, 32'h0000_0000, PAT_RANDOM, 8'd64, 1'b0, 1'b0},
    '{32'h1000_0000, 1'b1, 32'h0999_9999, PAT_RANDOM, 8'd64, 1'b0, 1'b0},
    '{32'h0123_4567, 1'b0, 32'h0000_0000, PAT_RANDOM, 8'd64, 1'b1, 1'b0},
    '{32'h0000_0000, 1'b0, 32'h0000_0000, PAT_RAMP,   8'd48, 1'b1, 1'b0},
    '{32'h0000_0000, 1'b0, 32'h0000_0000, PAT_STEPS,  8'd24, 1'b0, 1'b1}
};

logic            i_clock = 1'b0;
logic            i_arst_n;
sample_t         i_sample_early;
sample_t         i_sample_late;
logic            i_valid;
ddc_pkg::phase_t i_phase_inc;
logic            i_phase_inc_valid;
sample_t         o_inph;
sample_t         o_quad;
logic            o_valid;

ddc_pkg::phase_t model_phase = '0;
ddc_pkg::phase_t model_inc = '0;
int              inph_hist [7];
int              quad_hist [7];
int              pairs_seen = 0;
expect_t         pending [$];
int              cycle = 0;
int              errors = 0;
int              outputs = 0;
int              saturated = 0;
logic            timed_out = 1'b0;

ddc_top #(
    .WIDTH(WIDTH))
dut0 (
    .i_clock          (i_clock          ),
    .i_arst_n         (i_arst_n         ),
    .i_sample_early   (i_sample_early   ),
    .i_sample_late    (i_sample_late    ),
    .i_valid          (i_valid          ),
    .i_phase_inc      (i_phase_inc      ),
    .i_phase_inc_valid(i_phase_inc_valid),
    .o_inph           (o_inph           ),
    .o_quad           (o_quad           ),
    .o_valid          (o_valid          ));

always #20 i_clock = ~i_clock;

always @(posedge i_clock) cycle <= cycle + 1;

// entry k is the amplitude times cos(2 pi k / 64), rounded to nearest.
function automatic int cos_entry(input int k);
    real angle;
    angle = 2.0 * PI * k / ddc_pkg::TABLE_SIZE;
    return $rtoi($floor(ddc_pkg::COEF_AMPLITUDE * $cos(angle) + 0.5));
endfunction

function automatic sample_t mix(input sample_t sample, input int coef);
    longint prod;
    prod = longint'(sample) * longint'(coef);
    prod = (prod + 64'sd65536) >>> 17;
    return sample_t'(prod[WIDTH-1:0]); // only the low WIDTH bits survive.
endfunction

function automatic sample_t halfband(input int x0, input int x2, input int x3,
                                     input int x4, input int x6);
    int acc;
    acc = -x0 + 9 * x2 + 16 * x3 + 9 * x4 - x6;
    acc = (acc + 16) >>> 5;
    if (acc > MAX_VAL)
        acc = MAX_VAL;
    else if (acc < MIN_VAL)
        acc = MIN_VAL;
    return sample_t'(acc);
endfunction

function automatic sample_t sample_at(input pattern_t pattern, input int m);
    case (pattern)
        PAT_CONST: return sample_t'(12000);
        PAT_RAMP: return sample_t'(m * 4369); // sawtooth over the full range.
        PAT_RANDOM: return sample_t'($urandom());
        default: return ((m % 6) >= 1 && (m % 6) <= 3) ? sample_t'(MAX_VAL) : sample_t'(MIN_VAL);
    endcase
endfunction

task automatic model_pair(input sample_t early, input sample_t late, input int issued);
    ddc_pkg::phase_t phase_late;
    int idx_early;
    int idx_late;
    expect_t e;
    phase_late = model_phase + model_inc;
    idx_early = int'(model_phase[ddc_pkg::PHASE_WIDTH-1 -: ddc_pkg::TABLE_BITS]);
    idx_late = int'(phase_late[ddc_pkg::PHASE_WIDTH-1 -: ddc_pkg::TABLE_BITS]);
    for (int k = 6; k >= 2; k--) begin
        inph_hist[k] = inph_hist[k-2];
        quad_hist[k] = quad_hist[k-2];
    end
    inph_hist[1] = int'(mix(early, cos_entry(idx_early)));
    quad_hist[1] = int'(mix(early, -cos_entry((idx_early + 64 - 16) % 64)));
    inph_hist[0] = int'(mix(late, cos_entry(idx_late)));
    quad_hist[0] = int'(mix(late, -cos_entry((idx_late + 64 - 16) % 64)));
    pairs_seen++;
    e.inph = halfband(inph_hist[0], inph_hist[2], inph_hist[3], inph_hist[4], inph_hist[6]);
    e.quad = halfband(quad_hist[0], quad_hist[2], quad_hist[3], quad_hist[4], quad_hist[6]);
    e.check = (pairs_seen >= 4); // the filter history is unknown for three pairs after reset.
    e.cycle = issued;
    pending.push_back(e);
    model_phase = model_phase + (model_inc << 1);
endtask

task automatic drive_cycle(input logic valid, input sample_t early, input sample_t late,
                           input logic inc_valid, input ddc_pkg::phase_t inc);
    @(posedge i_clock);
    #2;
    i_valid = valid;
    i_sample_early = early;
    i_sample_late = late;
    i_phase_inc_valid = inc_valid;
    i_phase_inc = inc;
endtask

task automatic write_inc(input ddc_pkg::phase_t inc);
    drive_cycle(1'b0, sample_t'(0), sample_t'(0), 1'b1, inc);
    model_phase = '0;
    model_inc = inc;
endtask

task automatic drain(output logic done);
    int waited;
    waited = 0;
    drive_cycle(1'b0, sample_t'(0), sample_t'(0), 1'b0, i_phase_inc);
    while (pending.size() > 0 && waited < DRAIN_TIMEOUT) begin
        @(posedge i_clock);
        waited++;
    end
    done = (pending.size() == 0);
endtask

// outputs are compared at the falling edge, away from the driving edge.
always @(negedge i_clock) begin
    expect_t e;
    if (o_valid === 1'b1) begin
        assert (pending.size() > 0)
        else begin
            $display("output valid seen with no sample pair in flight");
            errors++;
        end
        if (pending.size() > 0) begin
            e = pending.pop_front();
            outputs++;
            assert (cycle - e.cycle == LATENCY)
            else begin
                $display("output came %0d cycles after its pair instead of %0d",
                         cycle - e.cycle, LATENCY);
                errors++;
            end
            if (e.check) begin
                assert (o_inph === e.inph)
                else begin
                    $display("FAIL o_inph expected 0x%h got 0x%h", e.inph, o_inph);
                    errors++;
                end
                assert (o_quad === e.quad)
                else begin
                    $display("FAIL o_quad expected 0x%h got 0x%h", e.quad, o_quad);
                    errors++;
                end
                if (o_inph === sample_t'(MAX_VAL) || o_inph === sample_t'(MIN_VAL)) begin
                    saturated++;
                end
            end
        end
    end
end

initial begin
    int unsigned seed;
    int errors_before;
    int outputs_before;
    logic done;
    sample_t early;
    sample_t late;
    seed = $urandom(26573);
    i_arst_n = 1'b0;
    i_valid = 1'b0;
    i_sample_early = '0;
    i_sample_late = '0;
    i_phase_inc = '0;
    i_phase_inc_valid = 1'b0;
    repeat (2) @(posedge i_clock);
    #2;
    i_arst_n = 1'b1;

    errors_before = errors;
    repeat (20) begin
        @(negedge i_clock);
        assert (o_valid === 1'b0)
        else begin
            $display("FAIL o_valid expected 0x0 got 0x%h", o_valid);
            errors++;
        end
    end
    $display("idle_after_reset: 20 cycles, %0d errors", errors - errors_before);

    for (int r = 0; r < NUM_ROWS; r++) begin
        errors_before = errors;
        outputs_before = outputs;
        saturated = 0;
        write_inc(rows[r].phase_inc);
        for (int p = 0; p < int'(rows[r].pairs); p++) begin
            if (rows[r].retune && p == int'(rows[r].pairs) / 2) begin
                write_inc(rows[r].retune_inc);
            end
            if (rows[r].gaps) begin
                repeat ($urandom_range(0, 2)) begin
                    drive_cycle(1'b0, sample_t'(0), sample_t'(0), 1'b0, i_phase_inc);
                end
            end
            early = sample_at(rows[r].pattern, 2 * p);
            late = sample_at(rows[r].pattern, 2 * p + 1);
            drive_cycle(1'b1, early, late, 1'b0, i_phase_inc);
            model_pair(early, late, cycle);
        end
        drain(done);
        if (!done) begin
            $display("%s: timed out with %0d outputs still missing", row_names[r],
                     pending.size());
            timed_out = 1'b1;
            break;
        end
        if (rows[r].expect_sat) begin
            assert (saturated > 0)
            else begin
                $display("%s: no output reached the saturation limit", row_names[r]);
                errors++;
            end
        end
        $display("%s: %0d outputs, %0d errors", row_names[r], outputs - outputs_before,
                 errors - errors_before);
    end

    $display("checked %0d outputs in total, %0d errors", outputs, errors);
    if (errors == 0 && !timed_out) begin
        $display("Test passed");
    end else begin
        $display("Test failed");
    end
    $finish;
end

endmodule

`default_nettype wire

// ==== logic/ddc_top.sv ====
`timescale 1ns/1ps

`default_nettype none

module ddc_top #(
    parameter integer WIDTH = 16
) (
    input  wire logic                    i_clock,
    input  wire logic                    i_arst_n,
    input  wire logic signed [WIDTH-1:0] i_sample_early,
    input  wire logic signed [WIDTH-1:0] i_sample_late,
    input  wire logic                    i_valid,
    input  wire ddc_pkg::phase_t         i_phase_inc,
    input  wire logic                    i_phase_inc_valid,
    output      logic signed [WIDTH-1:0] o_inph,
    output      logic signed [WIDTH-1:0] o_quad,
    output      logic                    o_valid
);

ddc_pkg::coef_t cos_early;
ddc_pkg::coef_t sin_early;
ddc_pkg::coef_t cos_late;
ddc_pkg::coef_t sin_late;
logic           coef_valid;

logic signed [WIDTH-1:0] mix_inph_early;
logic signed [WIDTH-1:0] mix_quad_early;
logic signed [WIDTH-1:0] mix_inph_late;
logic signed [WIDTH-1:0] mix_quad_late;
logic                    mix_valid;

ddc_nco_x2 nco_inst (
    .i_clock          (i_clock          ),
    .i_arst_n         (i_arst_n         ),
    .i_valid          (i_valid          ),
    .i_phase_inc      (i_phase_inc      ),
    .i_phase_inc_valid(i_phase_inc_valid),
    .o_cos_early      (cos_early        ),
    .o_sin_early      (sin_early        ),
    .o_cos_late       (cos_late         ),
    .o_sin_late       (sin_late         ),
    .o_valid          (coef_valid       ));

ddc_mixer #(
    .WIDTH(WIDTH))
mixer_inst (
    .i_clock       (i_clock       ),
    .i_arst_n      (i_arst_n      ),
    .i_sample_early(i_sample_early),
    .i_sample_late (i_sample_late ),
    .i_valid       (i_valid       ),
    .i_cos_early   (cos_early     ),
    .i_sin_early   (sin_early     ),
    .i_cos_late    (cos_late      ),
    .i_sin_late    (sin_late      ),
    .i_coef_valid  (coef_valid    ),
    .o_inph_early  (mix_inph_early),
    .o_quad_early  (mix_quad_early),
    .o_inph_late   (mix_inph_late ),
    .o_quad_late   (mix_quad_late ),
    .o_valid       (mix_valid     ));

ddc_halfband #(
    .WIDTH(WIDTH))
halfband_inst (
    .i_clock     (i_clock       ),
    .i_arst_n    (i_arst_n      ),
    .i_inph_early(mix_inph_early),
    .i_quad_early(mix_quad_early),
    .i_inph_late (mix_inph_late ),
    .i_quad_late (mix_quad_late ),
    .i_valid     (mix_valid     ),
    .o_inph      (o_inph        ),
    .o_quad      (o_quad        ),
    .o_valid     (o_valid       ));

endmodule

`default_nettype wire

// ==== logic/ddc_halfband.sv ====
`timescale 1ns/1ps

`default_nettype none

module ddc_halfband #(
    parameter integer WIDTH = 16
) (
    input  wire logic                    i_clock,
    input  wire logic                    i_arst_n,
    input  wire logic signed [WIDTH-1:0] i_inph_early,
    input  wire logic signed [WIDTH-1:0] i_quad_early,
    input  wire logic signed [WIDTH-1:0] i_inph_late,
    input  wire logic signed [WIDTH-1:0] i_quad_late,
    input  wire logic                    i_valid,
    output      logic signed [WIDTH-1:0] o_inph,
    output      logic signed [WIDTH-1:0] o_quad,
    output      logic                    o_valid
);

localparam integer TAPS = 7;
localparam integer COEF_SHIFT = 5; // coefficients are over 32.
localparam integer SUM_WIDTH = WIDTH + 6;
localparam logic signed [SUM_WIDTH-1:0] ROUND_BIAS = SUM_WIDTH'(2 ** (COEF_SHIFT - 1));

// taps -1, 0, 9, 16, 9, 0, -1 with x0 the newest sample.
function automatic logic signed [SUM_WIDTH-1:0] tap_sum(
    input logic signed [WIDTH-1:0] x0,
    input logic signed [WIDTH-1:0] x2,
    input logic signed [WIDTH-1:0] x3,
    input logic signed [WIDTH-1:0] x4,
    input logic signed [WIDTH-1:0] x6
);
    logic signed [SUM_WIDTH-1:0] outer;
    logic signed [SUM_WIDTH-1:0] inner;
    logic signed [SUM_WIDTH-1:0] center;
    outer = SUM_WIDTH'(x0) + SUM_WIDTH'(x6);
    inner = SUM_WIDTH'(x2) + SUM_WIDTH'(x4);
    center = SUM_WIDTH'(x3) <<< 4;
    return center + (inner <<< 3) + inner - outer;
endfunction

function automatic logic signed [WIDTH-1:0] round_saturate(
    input logic signed [SUM_WIDTH-1:0] sum
);
    logic signed [SUM_WIDTH-1:0] biased;
    logic signed [WIDTH:0] scaled;
    biased = sum + ROUND_BIAS;
    scaled = biased[SUM_WIDTH-1:COEF_SHIFT]; // gain stays below 2, so one extra bit is enough.
    if (scaled[WIDTH] != scaled[WIDTH-1]) begin
        return scaled[WIDTH] ? {1'b1, {(WIDTH-1){1'b0}}} : {1'b0, {(WIDTH-1){1'b1}}};
    end
    return scaled[WIDTH-1:0];
endfunction

// index 0 holds the newest sample of each channel.
logic signed [WIDTH-1:0] inph_hist [TAPS];
logic signed [WIDTH-1:0] quad_hist [TAPS];

logic valid_reg1;

always_ff @(posedge i_clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
        valid_reg1 <= 1'b0;
        o_valid <= 1'b0;
    end else begin
        valid_reg1 <= i_valid;
        o_valid <= valid_reg1;
    end
end

always_ff @(posedge i_clock) begin
    if (i_valid) begin
        inph_hist[0] <= i_inph_late;
        inph_hist[1] <= i_inph_early;
        quad_hist[0] <= i_quad_late;
        quad_hist[1] <= i_quad_early;
        for (int k = 2; k < TAPS; k++) begin
            inph_hist[k] <= inph_hist[k-2]; // two samples enter per pair.
            quad_hist[k] <= quad_hist[k-2];
        end
    end
    if (valid_reg1) begin
        o_inph <= round_saturate(tap_sum(inph_hist[0], inph_hist[2], inph_hist[3],
                                         inph_hist[4], inph_hist[6]));
        o_quad <= round_saturate(tap_sum(quad_hist[0], quad_hist[2], quad_hist[3],
                                         quad_hist[4], quad_hist[6]));
    end
end

assert property (@(posedge i_clock) disable iff (!i_arst_n)
    o_valid == $past(i_valid, 2))
    else $error("halfband output valid is not two cycles behind its input");

endmodule

`default_nettype wire

// ==== logic/ddc_mixer.sv ====
`timescale 1ns/1ps

`default_nettype none

module ddc_mixer #(
    parameter integer WIDTH = 16
) (
    input  wire logic                    i_clock,
    input  wire logic                    i_arst_n,
    input  wire logic signed [WIDTH-1:0] i_sample_early,
    input  wire logic signed [WIDTH-1:0] i_sample_late,
    input  wire logic                    i_valid,
    input  wire ddc_pkg::coef_t          i_cos_early,
    input  wire ddc_pkg::coef_t          i_sin_early,
    input  wire ddc_pkg::coef_t          i_cos_late,
    input  wire ddc_pkg::coef_t          i_sin_late,
    input  wire logic                    i_coef_valid,
    output      logic signed [WIDTH-1:0] o_inph_early,
    output      logic signed [WIDTH-1:0] o_quad_early,
    output      logic signed [WIDTH-1:0] o_inph_late,
    output      logic signed [WIDTH-1:0] o_quad_late,
    output      logic                    o_valid
);

localparam integer PROD_WIDTH = WIDTH + ddc_pkg::COEF_WIDTH;
localparam integer ROUND_SHIFT = ddc_pkg::COEF_WIDTH - 1;
localparam logic signed [PROD_WIDTH-1:0] ROUND_BIAS = PROD_WIDTH'(2 ** (ROUND_SHIFT - 1));

// round half up and drop the coefficient scale, keeping WIDTH bits.
function automatic logic signed [WIDTH-1:0] round_product(
    input logic signed [PROD_WIDTH-1:0] prod
);
    logic signed [PROD_WIDTH-1:0] biased;
    biased = prod + ROUND_BIAS;
    return biased[ROUND_SHIFT+WIDTH-1:ROUND_SHIFT];
endfunction

logic signed [WIDTH-1:0] sample_early_reg0;
logic signed [WIDTH-1:0] sample_late_reg0;

logic signed [PROD_WIDTH-1:0] inph_early_reg1;
logic signed [PROD_WIDTH-1:0] quad_early_reg1;
logic signed [PROD_WIDTH-1:0] inph_late_reg1;
logic signed [PROD_WIDTH-1:0] quad_late_reg1;

logic signed [WIDTH-1:0] inph_early_reg2;
logic signed [WIDTH-1:0] quad_early_reg2;
logic signed [WIDTH-1:0] inph_late_reg2;
logic signed [WIDTH-1:0] quad_late_reg2;

logic valid_reg0;
logic valid_reg1;
logic valid_reg2;

always_ff @(posedge i_clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
        valid_reg0 <= 1'b0;
        valid_reg1 <= 1'b0;
        valid_reg2 <= 1'b0;
        o_valid <= 1'b0;
    end else begin
        valid_reg0 <= i_valid;
        valid_reg1 <= valid_reg0;
        valid_reg2 <= valid_reg1;
        o_valid <= valid_reg2;
    end
end

always_ff @(posedge i_clock) begin
    // the oscillator registers its values on this same edge.
    sample_early_reg0 <= i_sample_early;
    sample_late_reg0 <= i_sample_late;

    inph_early_reg1 <= sample_early_reg0 * i_cos_early;
    quad_early_reg1 <= -(sample_early_reg0 * i_sin_early); // quadrature mixes with -sin.
    inph_late_reg1 <= sample_late_reg0 * i_cos_late;
    quad_late_reg1 <= -(sample_late_reg0 * i_sin_late);

    inph_early_reg2 <= round_product(inph_early_reg1);
    quad_early_reg2 <= round_product(quad_early_reg1);
    inph_late_reg2 <= round_product(inph_late_reg1);
    quad_late_reg2 <= round_product(quad_late_reg1);

    o_inph_early <= inph_early_reg2;
    o_quad_early <= quad_early_reg2;
    o_inph_late <= inph_late_reg2;
    o_quad_late <= quad_late_reg2;
end

// coefficients must meet their samples in stage 0.
assert property (@(posedge i_clock) disable iff (!i_arst_n)
    i_coef_valid == $past(i_valid))
    else $error("oscillator values out of step with the sample pairs");

endmodule

`default_nettype wire

// ==== logic/ddc_nco_x2.sv ====
`timescale 1ns/1ps

`default_nettype none

module ddc_nco_x2 (
    input  wire logic             i_clock,
    input  wire logic             i_arst_n,
    input  wire logic             i_valid,
    input  wire ddc_pkg::phase_t  i_phase_inc,
    input  wire logic             i_phase_inc_valid,
    output      ddc_pkg::coef_t   o_cos_early,
    output      ddc_pkg::coef_t   o_sin_early,
    output      ddc_pkg::coef_t   o_cos_late,
    output      ddc_pkg::coef_t   o_sin_late,
    output      logic             o_valid
);

localparam real PI = 3.14159265358979323846;
localparam integer TB = ddc_pkg::TABLE_BITS;
localparam integer PW = ddc_pkg::PHASE_WIDTH;

// sine is the cosine a quarter turn back.
localparam logic [TB-1:0] QUARTER = TB'(ddc_pkg::TABLE_SIZE / 4);

ddc_pkg::coef_t cos_table [ddc_pkg::TABLE_SIZE];

ddc_pkg::phase_t phase_inc;
ddc_pkg::phase_t phase_acc;
ddc_pkg::phase_t phase_late;

logic [TB-1:0] idx_early;
logic [TB-1:0] idx_late;
logic [TB-1:0] sin_idx_early;
logic [TB-1:0] sin_idx_late;

initial begin
    real angle;
    for (int k = 0; k < ddc_pkg::TABLE_SIZE; k++) begin
        angle = 2.0 * PI * k / ddc_pkg::TABLE_SIZE;
        cos_table[k] = ddc_pkg::coef_t'($rtoi($floor(ddc_pkg::COEF_AMPLITUDE * $cos(angle) + 0.5)));
    end
end

assign phase_late = phase_acc + phase_inc; // the late sample is one increment ahead.

assign idx_early = phase_acc[PW-1:PW-TB];
assign idx_late = phase_late[PW-1:PW-TB];
assign sin_idx_early = idx_early - QUARTER; // wraps modulo the table size.
assign sin_idx_late = idx_late - QUARTER;

always_ff @(posedge i_clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
        phase_inc <= '0;
        phase_acc <= '0;
        o_valid <= 1'b0;
    end else begin
        o_valid <= i_valid;
        if (i_phase_inc_valid) begin
            phase_inc <= i_phase_inc;
            phase_acc <= '0; // a new tone starts from phase zero.
        end else if (i_valid) begin
            phase_acc <= phase_acc + (phase_inc << 1);
        end
    end
end

always_ff @(posedge i_clock) begin
    if (i_valid) begin
        o_cos_early <= cos_table[idx_early];
        o_sin_early <= cos_table[sin_idx_early];
        o_cos_late <= cos_table[idx_late];
        o_sin_late <= cos_table[sin_idx_late];
    end
end

// a new increment must not land on a sample pair.
assert property (@(posedge i_clock) disable iff (!i_arst_n)
    !(i_phase_inc_valid && i_valid))
    else $error("phase increment written in a cycle with a valid sample pair");

endmodule

`default_nettype wire

// ==== logic/ddc_pkg.sv ====
`default_nettype none

package ddc_pkg;

    // phase accumulator and increment.
    localparam integer PHASE_WIDTH = 32;
    typedef logic [PHASE_WIDTH-1:0] phase_t;

    // oscillator table, indexed by the upper phase bits.
    localparam integer TABLE_BITS = 6;
    localparam integer TABLE_SIZE = 2 ** TABLE_BITS;

    // signed oscillator outputs.
    localparam integer COEF_WIDTH = 18;
    typedef logic signed [COEF_WIDTH-1:0] coef_t;

    // full scale of the table, 2^17 - 1.
    localparam integer COEF_AMPLITUDE = 131071;

endpackage

`default_nettype wire
